// File: common/emac_defs.svh
// ================================================
// EMAC management shared constants
// Register bus widths, register map offsets and
// MDIO bit timing
// ================================================
`ifndef EMAC_DEFS_SVH
`define EMAC_DEFS_SVH

// Register bus
`define EMAC_DATA_W 32
`define EMAC_ADDR_W 12

// Register map
`define EMAC_OFS_MACL 12'h000
`define EMAC_OFS_MACH 12'h004
`define EMAC_OFS_CTRL 12'h008
`define EMAC_OFS_ISR  12'h00C
`define EMAC_OFS_IMR  12'h010
`define EMAC_OFS_MCR  12'h300
`define EMAC_OFS_MDR  12'h304
`define EMAC_MCR_BUSY_BIT 31

// MDIO timing, clk cycles per mdc half period
`define EMAC_MDC_DIV      4
`define EMAC_PREAMBLE_LEN 32

`endif

// File: common/emac_csr_pkg.sv
// ================================================
// EMAC register bus types
// Register offsets and static MAC configuration
// ================================================
`include "emac_defs.svh"

package emac_csr_pkg;

   // ================================================
   // Register offsets
   // ================================================
   typedef enum logic [`EMAC_ADDR_W-1:0]
   {
      MACL = `EMAC_OFS_MACL,
      MACH = `EMAC_OFS_MACH,
      CTRL = `EMAC_OFS_CTRL,
      ISR  = `EMAC_OFS_ISR,
      IMR  = `EMAC_OFS_IMR,
      // MDIO management block
      MCR  = `EMAC_OFS_MCR,
      MDR  = `EMAC_OFS_MDR
   } csr_offset_e;

   // ================================================
   // Static configuration
   // ================================================
   typedef struct packed
   {
      logic [47:0] mac_addr;
      logic        tx_enable;
      logic        rx_enable;
   } emac_ctrl_t;

endpackage

// File: common/emac_miim_pkg.sv
// ================================================
// MII management (MDIO) types
// Clause 22 opcodes, frame engine states and the
// command handed from the register block
// ================================================

package emac_miim_pkg;

   // Clause 22 opcode field
   typedef enum logic [1:0]
   {
      MIIM_WRITE = 2'b01,
      MIIM_READ  = 2'b10
   } miim_op_e;

   // ================================================
   // Frame engine phases
   // ================================================
   typedef enum logic [2:0]
   {
      IDLE,
      PREAMBLE,
      HEADER,
      TURNAROUND,
      DATA,
      DONE
   } miim_state_e;

   // One management frame request
   typedef struct packed
   {
      miim_op_e    op;
      logic [4:0]  phy_addr;
      logic [4:0]  reg_addr;
      // Ignored on a read
      logic [15:0] wdata;
   } miim_cmd_t;

endpackage

// File: csr/emac_csr.sv
// ================================================
// EMAC register block
// Bus decoder, MAC and control registers, MDIO
// command and data, interrupt status and mask
// ================================================
`timescale 1ns/10ps
`include "emac_defs.svh"

module emac_csr
   import emac_csr_pkg::*, emac_miim_pkg::*;
(
   input  logic                    clk,
   input  logic                    SYNCHRONIZE_RESETS,
   input  logic [`EMAC_ADDR_W-1:0] addr,
   input  logic                    wr,
   input  logic                    rd,
   input  logic [`EMAC_DATA_W-1:0] wdata,
   input  logic                    miim_busy,
   input  logic                    miim_done,
   input  logic [15:0]             miim_rdata,
   output logic [`EMAC_DATA_W-1:0] rdata,
   output logic                    err,
   output logic                    irq,
   output emac_ctrl_t              ctrl,
   output logic                    miim_start,
   output miim_cmd_t               miim_cmd
);
   logic                    isr_q;
   logic                    imr_q;
   logic [15:0]             mdr_rdata_q;
   logic                    busy;
   logic                    hit;
   logic [`EMAC_DATA_W-1:0] rd_word;

   // Covers the cycle between the start strobe and the engine busy flag
   assign busy = miim_busy | miim_start;

   // ================================================
   // Read decode
   // ================================================
   always_comb
   begin
      hit     = 1'b1;
      rd_word = '0;
      case (addr)
         MACL: rd_word = ctrl.mac_addr[31:0];
         MACH: rd_word = `EMAC_DATA_W'(ctrl.mac_addr[47:32]);
         CTRL: rd_word = `EMAC_DATA_W'({ctrl.rx_enable, ctrl.tx_enable});
         ISR:  rd_word = `EMAC_DATA_W'(isr_q);
         IMR:  rd_word = `EMAC_DATA_W'(imr_q);
         MCR:
         begin
            rd_word[11:0]               = {miim_cmd.op, miim_cmd.reg_addr, miim_cmd.phy_addr};
            rd_word[`EMAC_MCR_BUSY_BIT] = busy;
         end
         MDR:  rd_word = `EMAC_DATA_W'(mdr_rdata_q);
         default: hit = 1'b0;
      endcase
   end

   assign rdata = rd ? rd_word : '0;
   assign err   = (wr || rd) && !hit;

   // ================================================
   // Register writes
   // ================================================
   always_ff @(posedge clk)
   begin
      if (SYNCHRONIZE_RESETS)
      begin
         ctrl        <= '0;
         miim_cmd    <= '0;
         miim_start  <= 1'b0;
         imr_q       <= 1'b0;
         isr_q       <= 1'b0;
         mdr_rdata_q <= '0;
         irq         <= 1'b0;
      end
      else
      begin
         miim_start <= 1'b0;
         if (wr)
         begin
            case (addr)
               MACL: ctrl.mac_addr[31:0]  <= wdata;
               MACH: ctrl.mac_addr[47:32] <= wdata[15:0];
               CTRL:
               begin
                  ctrl.tx_enable <= wdata[0];
                  ctrl.rx_enable <= wdata[1];
               end
               IMR: imr_q <= wdata[0];
               // New frame only when the engine is free
               MCR:
                  if (!busy)
                  begin
                     miim_cmd.phy_addr <= wdata[4:0];
                     miim_cmd.reg_addr <= wdata[9:5];
                     miim_cmd.op       <= miim_op_e'(wdata[11:10]);
                     miim_start        <= 1'b1;
                  end
               MDR: miim_cmd.wdata <= wdata[15:0];
               default: ;
            endcase
         end

         // Frame completion beats a software clear in the same cycle
         if (miim_done)
         begin
            isr_q       <= 1'b1;
            mdr_rdata_q <= miim_rdata;
         end
         else if (wr && addr == ISR && wdata[0])
            isr_q <= 1'b0;

         irq <= isr_q & imr_q;
      end
   end

   a_no_start_while_busy: assert property
      (@(posedge clk) disable iff (SYNCHRONIZE_RESETS) miim_start |-> !miim_busy);

endmodule

// File: miim/miim_frame_engine.sv
// ================================================
// MDIO frame engine
// Clause 22 sequencer: preamble, header, turnaround
// and 16 data bits, MSB first
// ================================================
`timescale 1ns/10ps
`include "emac_defs.svh"

module miim_frame_engine
   import emac_miim_pkg::*;
(
   input  logic        clk,
   input  logic        SYNCHRONIZE_RESETS,
   input  logic        start,
   input  miim_cmd_t   cmd,
   input  logic        bit_fall,
   input  logic        bit_rise,
   input  logic        mdi,
   output logic        busy,
   output logic        done,
   output logic [15:0] rdata,
   output logic        run,
   output logic        mdo,
   output logic        mdo_en
);
   // Start bits, opcode and both addresses
   localparam int HDR_BITS  = 14;
   localparam int TA_BITS   = 2;
   localparam int DATA_BITS = 16;
   localparam int FRAME_W   = HDR_BITS + TA_BITS + DATA_BITS;
   localparam int CNT_W     = $clog2(`EMAC_PREAMBLE_LEN);

   miim_state_e        state_q;
   logic [CNT_W-1:0]   bit_cnt_q;
   logic               rd_q;
   logic               last_bit;
   logic               shift_en;
   logic [FRAME_W-1:0] frame_q;

   always_comb
   begin
      case (state_q)
         PREAMBLE:   last_bit = (bit_cnt_q == CNT_W'(`EMAC_PREAMBLE_LEN - 1));
         HEADER:     last_bit = (bit_cnt_q == CNT_W'(HDR_BITS - 1));
         TURNAROUND: last_bit = (bit_cnt_q == CNT_W'(TA_BITS - 1));
         DATA:       last_bit = (bit_cnt_q == CNT_W'(DATA_BITS - 1));
         default:    last_bit = 1'b0;
      endcase
   end

   // Next frame bit goes out on every falling edge after the preamble
   assign shift_en = bit_fall && ((state_q == PREAMBLE && last_bit) || state_q == HEADER ||
                                  state_q == TURNAROUND || (state_q == DATA && !last_bit));

   // ================================================
   // Sequencer
   // ================================================
   always_ff @(posedge clk)
   begin
      if (SYNCHRONIZE_RESETS)
      begin
         state_q   <= IDLE;
         bit_cnt_q <= '0;
         rd_q      <= 1'b0;
         busy      <= 1'b0;
         done      <= 1'b0;
         run       <= 1'b0;
         mdo       <= 1'b1;
         mdo_en    <= 1'b0;
      end
      else
      begin
         done <= 1'b0;
         if (shift_en)
            mdo <= frame_q[FRAME_W-1];
         case (state_q)
            IDLE:
               if (start)
               begin
                  state_q   <= PREAMBLE;
                  bit_cnt_q <= '0;
                  rd_q      <= (cmd.op == MIIM_READ);
                  busy      <= 1'b1;
                  run       <= 1'b1;
                  mdo       <= 1'b1;
                  mdo_en    <= 1'b1;
               end
            PREAMBLE, HEADER, TURNAROUND, DATA:
               if (bit_fall)
               begin
                  bit_cnt_q <= last_bit ? '0 : bit_cnt_q + 1'b1;
                  if (last_bit)
                  begin
                     case (state_q)
                        PREAMBLE: state_q <= HEADER;
                        // PHY owns the line from the turnaround on a read
                        HEADER:
                        begin
                           state_q <= TURNAROUND;
                           mdo_en  <= !rd_q;
                        end
                        TURNAROUND: state_q <= DATA;
                        default:
                        begin
                           state_q <= DONE;
                           run     <= 1'b0;
                           mdo     <= 1'b1;
                           mdo_en  <= 1'b0;
                        end
                     endcase
                  end
               end
            DONE:
            begin
               state_q <= IDLE;
               busy    <= 1'b0;
               done    <= 1'b1;
            end
            default: state_q <= IDLE;
         endcase
      end
   end

   // Frame shifter and read data capture
   always_ff @(posedge clk)
   begin
      if (SYNCHRONIZE_RESETS)
      begin
         frame_q <= '0;
         rdata   <= '0;
      end
      else
      begin
         if (state_q == IDLE && start)
            frame_q <= {2'b01, cmd.op, cmd.phy_addr, cmd.reg_addr, 2'b10, cmd.wdata};
         else if (shift_en)
            frame_q <= {frame_q[FRAME_W-2:0], 1'b0};
         if (state_q == DATA && bit_rise && rd_q)
            rdata <= {rdata[14:0], mdi};
      end
   end

   a_read_data_released: assert property
      (@(posedge clk) disable iff (SYNCHRONIZE_RESETS) (state_q == DATA && rd_q) |-> !mdo_en);

endmodule

// File: miim/mdc_gen.sv
// ================================================
// MDC clock generator
// Divides clk down to mdc and marks the clk cycle
// before each mdc edge with a strobe
// ================================================
`timescale 1ns/10ps
`include "emac_defs.svh"

module mdc_gen
(
   input  logic clk,
   input  logic SYNCHRONIZE_RESETS,
   input  logic run,
   output logic mdc,
   output logic bit_fall,
   output logic bit_rise
);
   localparam int CNT_W = (`EMAC_MDC_DIV > 1) ? $clog2(`EMAC_MDC_DIV) : 1;

   logic [CNT_W-1:0] cnt_q;
   logic             last;

   // Final clk cycle of the current half period
   assign last = run && (cnt_q == CNT_W'(`EMAC_MDC_DIV - 1));

   // mdc toggles at the end of the strobe cycle
   assign bit_fall = last && mdc;
   assign bit_rise = last && !mdc;

   always_ff @(posedge clk)
   begin
      if (SYNCHRONIZE_RESETS || !run)
      begin
         cnt_q <= '0;
         mdc   <= 1'b0;
      end
      else if (last)
      begin
         cnt_q <= '0;
         mdc   <= !mdc;
      end
      else
         cnt_q <= cnt_q + 1'b1;
   end

   // High phase of mdc lasts one full half period
   a_high_phase: assert property
      (@(posedge clk) disable iff (SYNCHRONIZE_RESETS)
         bit_rise |-> ##(`EMAC_MDC_DIV) (bit_fall || !run));

endmodule

// File: hw/emac_mgmt_top.sv
// ================================================
// EMAC management top level
// Register bus, MDIO frame engine and MDC clock
// generator on a single clock
// ================================================
`timescale 1ns/10ps
`include "emac_defs.svh"

module emac_mgmt_top
   import emac_csr_pkg::*, emac_miim_pkg::*;
(
   input  logic                    clk,
   input  logic                    SYNCHRONIZE_RESETS,
   input  logic [`EMAC_ADDR_W-1:0] addr,
   input  logic                    wr,
   input  logic                    rd,
   input  logic [`EMAC_DATA_W-1:0] wdata,
   input  logic                    mdi,
   output logic [`EMAC_DATA_W-1:0] rdata,
   output logic                    err,
   output logic                    irq,
   output logic                    tx_enable,
   output logic                    rx_enable,
   output logic [47:0]             mac_addr,
   output logic                    mdc,
   output logic                    mdo,
   output logic                    mdo_en
);
   emac_ctrl_t  ctrl;
   miim_cmd_t   miim_cmd;
   logic        miim_start;
   logic        miim_busy;
   logic        miim_done;
   logic [15:0] miim_rdata;
   logic        run;
   logic        bit_fall;
   logic        bit_rise;

   assign mac_addr  = ctrl.mac_addr;
   assign tx_enable = ctrl.tx_enable;
   assign rx_enable = ctrl.rx_enable;

   emac_csr csr_i
   (
      .clk, .SYNCHRONIZE_RESETS, .addr, .wr, .rd, .wdata, .rdata, .err, .irq,
      .ctrl, .miim_start, .miim_cmd, .miim_busy, .miim_done, .miim_rdata
   );

   miim_frame_engine frame_engine_i
   (
      .clk, .SYNCHRONIZE_RESETS, .start(miim_start), .cmd(miim_cmd),
      .bit_fall, .bit_rise, .mdi, .busy(miim_busy), .done(miim_done),
      .rdata(miim_rdata), .run, .mdo, .mdo_en
   );

   mdc_gen mdc_gen_i
   (
      .clk, .SYNCHRONIZE_RESETS, .run, .mdc, .bit_fall, .bit_rise
   );

endmodule

// File: test/tb_emac_mgmt.sv
// ================================================
// EMAC management testbench
// Table-driven register and MDIO checks against a
// behavioral clause 22 PHY model
// ================================================
`timescale 1ns/10ps
`include "emac_defs.svh"

module tb_emac_mgmt
   import emac_csr_pkg::*, emac_miim_pkg::*;
();
   localparam int NUM_TESTS  = 9;
   localparam int MDIO_POLLS = 1000;

   typedef enum logic [2:0] {T_RESET, T_REG, T_BAD, T_MDIO_WR, T_MDIO_RD} test_kind_e;

   typedef struct packed
   {
      test_kind_e  kind;
      logic [11:0] ofs;
      logic [4:0]  phy;
      logic [4:0]  regad;
      logic [31:0] data;
      logic [31:0] exp;
   } test_rec_t;

   logic                    clk;
   logic                    SYNCHRONIZE_RESETS;
   logic [`EMAC_ADDR_W-1:0] addr;
   logic                    wr;
   logic                    rd;
   logic [`EMAC_DATA_W-1:0] wdata;
   logic                    mdi;
   logic [`EMAC_DATA_W-1:0] rdata;
   logic                    err;
   logic                    irq;
   logic                    tx_enable;
   logic                    rx_enable;
   logic [47:0]             mac_addr;
   logic                    mdc;
   logic                    mdo;
   logic                    mdo_en;

   test_rec_t   tests [NUM_TESTS];
   string       test_name [NUM_TESTS];
   logic [15:0] phy_regs [32];
   logic [13:0] seen_hdr;
   logic [15:0] seen_wdata;
   int          err_count;
   logic        test_err;
   logic        timed_out;

   emac_mgmt_top emac_mgmt_top_i
   (
      .clk, .SYNCHRONIZE_RESETS, .addr, .wr, .rd, .wdata, .mdi, .rdata, .err, .irq,
      .tx_enable, .rx_enable, .mac_addr, .mdc, .mdo, .mdo_en
   );

   initial
   begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   // ================================================
   // PHY model
   // ================================================
   initial
   begin : phy_model
      logic [15:0] shreg;
      int          n;
      mdi = 1'b1;
      forever
      begin
         // Preamble is all ones, the first driven zero is the start bit
         @(posedge mdc);
         while (!(mdo_en === 1'b1 && mdo === 1'b0))
            @(posedge mdc);
         seen_hdr = 14'h0;
         for (n = 0; n < 13; n++)
         begin
            @(posedge mdc);
            seen_hdr = {seen_hdr[12:0], mdo};
         end
         if (seen_hdr[11:10] == 2'b01)
         begin
            repeat (2) @(posedge mdc);
            for (n = 0; n < 16; n++)
            begin
               @(posedge mdc);
               shreg = {shreg[14:0], mdo};
            end
            seen_wdata = shreg;
            phy_regs[seen_hdr[4:0]] = shreg;
         end
         else if (seen_hdr[11:10] == 2'b10)
         begin
            shreg = phy_regs[seen_hdr[4:0]];
            @(negedge mdc);
            @(negedge mdc);
            mdi <= 1'b0;
            for (n = 15; n >= 0; n--)
            begin
               @(negedge mdc);
               mdi <= shreg[n];
            end
            @(negedge mdc);
            mdi <= 1'b1;
         end
      end
   end

   task automatic compare_value(input string name, input logic [31:0] exp,
                                input logic [31:0] act);
      if (act !== exp)
      begin
         $display("[ERROR] %s: expected 0x%08h, actual 0x%08h", name, exp, act);
         err_count++;
         test_err = 1'b1;
      end
   endtask

   task automatic bus_write(input logic [11:0] a, input logic [31:0] d, output logic e);
      @(posedge clk);
      addr  <= a;
      wdata <= d;
      wr    <= 1'b1;
      @(negedge clk);
      e = err;
      @(posedge clk);
      wr <= 1'b0;
   endtask

   task automatic bus_read(input logic [11:0] a, output logic [31:0] d, output logic e);
      @(posedge clk);
      addr <= a;
      rd   <= 1'b1;
      @(negedge clk);
      d = rdata;
      e = err;
      @(posedge clk);
      rd <= 1'b0;
   endtask

   task automatic wait_mdio_idle(output logic ok);
      logic [31:0] v;
      logic        e;
      int          n;
      ok = 1'b0;
      for (n = 0; n < MDIO_POLLS && !ok; n++)
      begin
         bus_read(MCR, v, e);
         ok = !v[`EMAC_MCR_BUSY_BIT];
      end
      if (!ok)
      begin
         $display("Timeout: MDIO frame still busy after %0d status reads", MDIO_POLLS);
         timed_out = 1'b1;
      end
   endtask

   task automatic add_test(input int idx, input string name, input test_kind_e kind,
                           input logic [11:0] ofs, input logic [4:0] phy,
                           input logic [4:0] regad, input logic [31:0] data,
                           input logic [31:0] exp);
      test_name[idx]   = name;
      tests[idx].kind  = kind;
      tests[idx].ofs   = ofs;
      tests[idx].phy   = phy;
      tests[idx].regad = regad;
      tests[idx].data  = data;
      tests[idx].exp   = exp;
   endtask

   // ================================================
   // Main sequence
   // ================================================
   initial
   begin : main
      logic [31:0] rnd;
      logic [31:0] v;
      logic [4:0]  phy_a;
      logic [4:0]  reg_a;
      logic [15:0] wr_val;
      logic        e;
      logic        ok;
      int          i;
      int          ok_tests;
      addr               = '0;
      wr                 = 1'b0;
      rd                 = 1'b0;
      wdata              = '0;
      SYNCHRONIZE_RESETS = 1'b1;
      err_count          = 0;
      ok_tests           = 0;
      timed_out          = 1'b0;
      rnd                = $urandom(96);
      for (i = 0; i < 32; i++)
         phy_regs[i] = $urandom;
      phy_a  = $urandom;
      reg_a  = $urandom;
      wr_val = $urandom;

      add_test(0, "reset_state", T_RESET, 12'h0, 5'h0, 5'h0, 32'h0, 32'h0);
      rnd = $urandom;
      add_test(1, "macl_rw", T_REG, MACL, 5'h0, 5'h0, rnd, rnd);
      rnd = $urandom;
      add_test(2, "mach_rw", T_REG, MACH, 5'h0, 5'h0, rnd, rnd & 32'hFFFF);
      rnd = $urandom;
      add_test(3, "ctrl_rw", T_REG, CTRL, 5'h0, 5'h0, rnd, rnd & 32'h3);
      rnd = $urandom | 32'h1;
      add_test(4, "imr_rw", T_REG, IMR, 5'h0, 5'h0, rnd, 32'h1);
      add_test(5, "bad_offset", T_BAD, 12'h020, 5'h0, 5'h0, $urandom, 32'h0);
      add_test(6, "mdio_write", T_MDIO_WR, MCR, phy_a, reg_a, {16'h0, wr_val}, {16'h0, wr_val});
      add_test(7, "mdio_read_back", T_MDIO_RD, MCR, phy_a, reg_a, 32'h0, {16'h0, wr_val});
      add_test(8, "mdio_read_preset", T_MDIO_RD, MCR, phy_a, reg_a ^ 5'h1, 32'h0,
               {16'h0, phy_regs[reg_a ^ 5'h1]});

      repeat (10) @(posedge clk);
      SYNCHRONIZE_RESETS <= 1'b0;

      for (i = 0; i < NUM_TESTS && !timed_out; i++)
      begin
         test_err = 1'b0;
         case (tests[i].kind)
            T_RESET:
            begin
               compare_value({test_name[i], " mdc"}, 32'h0, mdc);
               compare_value({test_name[i], " mdo_en"}, 32'h0, mdo_en);
               compare_value({test_name[i], " mdo"}, 32'h1, mdo);
               compare_value({test_name[i], " irq"}, 32'h0, irq);
               bus_read(MCR, v, e);
               compare_value({test_name[i], " busy"}, 32'h0, v[`EMAC_MCR_BUSY_BIT]);
            end
            T_REG:
            begin
               bus_write(tests[i].ofs, tests[i].data, e);
               compare_value({test_name[i], " err"}, 32'h0, e);
               bus_read(tests[i].ofs, v, e);
               compare_value({test_name[i], " readback"}, tests[i].exp, v);
               case (tests[i].ofs)
                  MACL: compare_value({test_name[i], " mac_addr"}, tests[i].exp,
                                      mac_addr[31:0]);
                  MACH: compare_value({test_name[i], " mac_addr"}, tests[i].exp,
                                      mac_addr[47:32]);
                  CTRL: compare_value({test_name[i], " enables"}, tests[i].exp,
                                      {rx_enable, tx_enable});
                  default: ;
               endcase
            end
            T_BAD:
            begin
               bus_write(tests[i].ofs, tests[i].data, e);
               compare_value({test_name[i], " write err"}, 32'h1, e);
               bus_read(tests[i].ofs, v, e);
               compare_value({test_name[i], " read err"}, 32'h1, e);
               compare_value({test_name[i], " rdata"}, 32'h0, v);
            end
            T_MDIO_WR:
            begin
               bus_write(MDR, tests[i].data, e);
               bus_write(MCR, {20'h0, MIIM_WRITE, tests[i].regad, tests[i].phy}, e);
               wait_mdio_idle(ok);
               if (ok)
               begin
                  compare_value({test_name[i], " start"}, 32'h1, seen_hdr[13:12]);
                  compare_value({test_name[i], " op"}, 32'h1, seen_hdr[11:10]);
                  compare_value({test_name[i], " phy"}, tests[i].phy, seen_hdr[9:5]);
                  compare_value({test_name[i], " reg"}, tests[i].regad, seen_hdr[4:0]);
                  compare_value({test_name[i], " wdata"}, tests[i].exp, seen_wdata);
                  bus_write(ISR, 32'h1, e);
               end
            end
            default:
            begin
               bus_write(MCR, {20'h0, MIIM_READ, tests[i].regad, tests[i].phy}, e);
               wait_mdio_idle(ok);
               if (ok)
               begin
                  bus_read(MDR, v, e);
                  compare_value({test_name[i], " mdr"}, tests[i].exp, v);
                  bus_read(ISR, v, e);
                  compare_value({test_name[i], " isr set"}, 32'h1, v);
                  compare_value({test_name[i], " irq set"}, 32'h1, irq);
                  bus_write(ISR, 32'h1, e);
                  bus_read(ISR, v, e);
                  compare_value({test_name[i], " isr clear"}, 32'h0, v);
                  compare_value({test_name[i], " irq clear"}, 32'h0, irq);
               end
            end
         endcase
         if (timed_out)
            $display("%-18s aborted", test_name[i]);
         else if (test_err)
            $display("%-18s mismatch", test_name[i]);
         else
         begin
            $display("%-18s ok", test_name[i]);
            ok_tests++;
         end
      end

      $display("tests ok: %0d, tests with errors: %0d, mismatches: %0d",
               ok_tests, NUM_TESTS - ok_tests, err_count);
      if (err_count == 0 && !timed_out && ok_tests == NUM_TESTS)
         $display("TEST RESULT: PASS");
      else
         $display("TEST RESULT: FAIL");
      $finish;
   end

endmodule

// File: project.f
+incdir+common
common/emac_csr_pkg.sv
common/emac_miim_pkg.sv
csr/emac_csr.sv
miim/miim_frame_engine.sv
miim/mdc_gen.sv
hw/emac_mgmt_top.sv
test/tb_emac_mgmt.sv
